// ==== logic/snd_consts.svh ====
`ifndef SND_CONSTS_SVH
`define SND_CONSTS_SVH

// bus and sample widths
`define SND_ROM_AW      17
`define SND_BANK_W      3
`define SND_RAM_AW      13
`define SND_WAVE_AW     10
`define SND_VOICE_W     11
`define SND_SAMPLE_W    16

// upper address nibble as casez patterns
`define SND_REGION_ROM0 4'b00??
`define SND_REGION_WAVE 4'b0101
`define SND_REGION_RAM  4'b100?
`define SND_REGION_REG  4'b11??

// register select on A[13:12]
`define SND_REG_BANK    2'd0
`define SND_REG_IRQACK  2'd2

`define SND_GAIN_PCM    8'h10   // unity in 4.4
`define SND_GAIN_WAVE   8'h10   // unity in 4.4

`define SND_VOICE_BASE  10'h3f0

`endif

// ==== logic/snd_pkg.sv ====
`default_nettype none

`include "snd_consts.svh"

package snd_pkg;

    // one processor access, stb marks the request cycle
    typedef struct packed {
        logic [15:0] addr;
        logic        rnw;
        logic [7:0]  wdata;
        logic        stb;
    } snd_req_t;

    // processor address seen as a map entry or as a banked ROM address
    typedef union packed {
        struct packed {
            logic [3:0]  region;
            logic [11:0] offset;
        } map;
        struct packed {
            logic [1:0]  window;    // 2'b11 is the fixed bank 0 window
            logic [13:0] page;
        } rom;
    } snd_addr_u;

    typedef struct packed {
        logic                    cs;
        logic                    rnw;
        logic [`SND_WAVE_AW-1:0] addr;
        logic [7:0]              data;
    } snd_bus_t;

    typedef struct packed {
        logic signed [`SND_SAMPLE_W-1:0] left;
        logic signed [`SND_SAMPLE_W-1:0] right;
    } snd_sample_t;

endpackage

`default_nettype wire

// ==== logic/snd_bus_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "snd_consts.svh"

module snd_bus_ctrl (
    input  wire                       clk,
    input  wire                       srst_n,
    input  wire                       lvbl,
    input  wire  snd_pkg::snd_req_t   cpu_req,
    input  wire  [7:0]                rom_data,
    input  wire                       rom_ok,
    input  wire  [7:0]                ram_rdata,
    input  wire  [7:0]                wave_rdata,
    output logic                      rom_cs,
    output logic [`SND_ROM_AW-1:0]    rom_addr,
    output logic                      bus_busy,
    output logic                      ram_we,
    output logic [`SND_RAM_AW-1:0]    ram_addr,
    output logic [7:0]                ram_wdata,
    output snd_pkg::snd_bus_t         wave_bus,
    output logic [7:0]                rd_data,
    output logic                      rd_valid,
    output logic                      irq_n
);

    snd_pkg::snd_addr_u    addr;
    logic                  accept;
    logic                  rom_rd, wave_acc, ram_acc, reg_wr, null_rd;
    logic                  rom_done;
    logic [1:0]            reg_sel;
    logic [`SND_BANK_W-1:0] bank;
    logic                  lvbl_l;
    logic                  rd_pend;     // non-ROM read in flight
    logic                  src_ram, src_wave;

    assign addr     = cpu_req.addr;
    assign bus_busy = rom_cs;           // requests are dropped while high
    assign accept   = cpu_req.stb & ~bus_busy;
    assign rom_done = rom_cs & rom_ok;
    assign reg_sel  = addr.rom.page[13:12];

    always_comb begin
        rom_rd   = 1'b0;
        wave_acc = 1'b0;
        ram_acc  = 1'b0;
        reg_wr   = 1'b0;
        null_rd  = 1'b0;
        if (accept) begin
            casez (addr.map.region)
                `SND_REGION_ROM0: rom_rd   = cpu_req.rnw;
                `SND_REGION_WAVE: wave_acc = 1'b1;
                `SND_REGION_RAM:  ram_acc  = 1'b1;
                `SND_REGION_REG: begin
                    // reads here fetch bank 0, writes hit the registers
                    rom_rd = cpu_req.rnw;
                    reg_wr = ~cpu_req.rnw;
                end
                default:          null_rd  = cpu_req.rnw; // open bus reads 0
            endcase
        end
    end

    // work RAM port, A12 comes from the region nibble
    assign ram_we    = ram_acc & ~cpu_req.rnw;
    assign ram_addr  = {addr.map.region[0], addr.map.offset};
    assign ram_wdata = cpu_req.wdata;

    always_comb begin
        wave_bus.cs   = wave_acc;
        wave_bus.rnw  = cpu_req.rnw;
        wave_bus.addr = addr.map.offset[`SND_WAVE_AW-1:0];
        wave_bus.data = cpu_req.wdata;
    end

    always_ff @(posedge clk, negedge srst_n) begin
        if (!srst_n) begin
            rom_cs   <= 1'b0;
            bank     <= '0;
            irq_n    <= 1'b1;
            lvbl_l   <= 1'b0;
            rd_pend  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            lvbl_l   <= lvbl;
            rd_pend  <= ((ram_acc | wave_acc) & cpu_req.rnw) | null_rd;
            rd_valid <= rd_pend | rom_done;
            if (rom_rd) begin
                rom_cs <= 1'b1;
            end else if (rom_done) begin
                rom_cs <= 1'b0;
            end
            if (reg_wr && reg_sel == `SND_REG_BANK) begin
                bank <= cpu_req.wdata[4 +: `SND_BANK_W];
            end
            if (reg_wr && reg_sel == `SND_REG_IRQACK) irq_n <= 1'b1;
            if (!lvbl && lvbl_l) irq_n <= 1'b0;    // edge wins over ack
        end
    end

    always_ff @(posedge clk) begin
        if (rom_rd) begin
            rom_addr <= {addr.rom.window == 2'b11 ? {`SND_BANK_W{1'b0}} : bank,
                         addr.rom.page};
        end
        src_ram  <= ram_acc;
        src_wave <= wave_acc;
        if (rom_done) begin
            rd_data <= rom_data;
        end else if (rd_pend) begin
            rd_data <= src_ram  ? ram_rdata  :
                       src_wave ? wave_rdata : 8'd0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/wave_voice.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "snd_consts.svh"

module wave_voice (
    input  wire                             clk,
    input  wire                             srst_n,
    input  wire                             cen,
    input  wire  snd_pkg::snd_bus_t         main_bus,
    input  wire  snd_pkg::snd_bus_t         snd_bus,
    output logic [7:0]                      main_rdata,
    output logic [7:0]                      snd_rdata,
    output logic signed [`SND_VOICE_W-1:0]  voice_l,
    output logic signed [`SND_VOICE_W-1:0]  voice_r
);

    localparam logic [`SND_WAVE_AW-1:0] VBASE = `SND_VOICE_BASE;

    logic [7:0]              mem [0:(1<<`SND_WAVE_AW)-1];
    snd_pkg::snd_bus_t       pend, snd_cur, port;
    logic                    pend_vld;
    logic                    vreg_we;
    logic [19:0]             freq;
    logic [19:0]             phase;
    logic [3:0]              wave_sel;
    logic [3:0]              vol_l, vol_r;
    logic [`SND_WAVE_AW-1:0] wave_addr;
    logic [7:0]              wave_byte;
    logic [3:0]              nib;
    logic signed [4:0]       nib_s;

    // main board owns the shared port and a colliding sound access waits a cycle
    assign snd_cur = pend_vld ? pend : snd_bus;
    assign port    = main_bus.cs ? main_bus : snd_cur;

    always_ff @(posedge clk, negedge srst_n) begin
        if (!srst_n) begin
            pend_vld <= 1'b0;
        end else begin
            pend_vld <= main_bus.cs & snd_cur.cs;
        end
    end

    always_ff @(posedge clk) begin
        pend <= snd_cur;
    end

    // shared port A
    always_ff @(posedge clk) begin
        if (port.cs && !port.rnw) mem[port.addr] <= port.data;
        if (port.cs && port.rnw) begin
            if (main_bus.cs) begin
                main_rdata <= mem[port.addr];
            end else begin
                snd_rdata <= mem[port.addr];
            end
        end
    end

    // voice registers are also kept in flops so the voice never waits
    assign vreg_we = port.cs & ~port.rnw &
                     (port.addr[`SND_WAVE_AW-1:2] == VBASE[`SND_WAVE_AW-1:2]);

    always_ff @(posedge clk, negedge srst_n) begin
        if (!srst_n) begin
            freq     <= '0;
            wave_sel <= '0;
            vol_l    <= '0;
            vol_r    <= '0;
        end else if (vreg_we) begin
            case (port.addr[1:0])
                2'd0: freq[7:0]  <= port.data;
                2'd1: freq[15:8] <= port.data;
                2'd2: {wave_sel, vol_l} <= port.data;
                2'd3: {freq[19:16], vol_r} <= port.data;   // top freq bits ride along
                default: ;
            endcase
        end
    end

    // port B fetches from 32 byte waves with the high nibble first
    assign wave_addr = {1'b0, wave_sel, phase[19:15]};
    assign wave_byte = mem[wave_addr];
    assign nib       = phase[14] ? wave_byte[3:0] : wave_byte[7:4];
    assign nib_s     = $signed({1'b0, nib}) - 5'sd8;

    always_ff @(posedge clk, negedge srst_n) begin
        if (!srst_n) begin
            phase   <= '0;
            voice_l <= '0;
            voice_r <= '0;
        end else if (cen) begin
            phase   <= phase + freq;
            voice_l <= nib_s * $signed({1'b0, vol_l});
            voice_r <= nib_s * $signed({1'b0, vol_r});
        end
    end

endmodule

`default_nettype wire

// ==== logic/snd_mixer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "snd_consts.svh"

module snd_mixer (
    input  wire                              clk,
    input  wire                              srst_n,
    input  wire  signed [`SND_VOICE_W-1:0]   wave_ch,
    input  wire  signed [`SND_VOICE_W-1:0]   pcm_ch,
    output logic signed [`SND_SAMPLE_W-1:0]  mixed,
    output logic                             peak
);

    localparam int AL = `SND_SAMPLE_W - `SND_VOICE_W;  // input left alignment
    localparam int PW = `SND_SAMPLE_W + 9;              // sample x signed gain
    localparam int SW = PW + 1;
    localparam int RW = SW - 4;                         // after the 4.4 shift
    localparam logic signed [RW-1:0] MAXV = 2**(`SND_SAMPLE_W-1) - 1;
    localparam logic signed [RW-1:0] MINV = -(2**(`SND_SAMPLE_W-1));

    logic signed [`SND_SAMPLE_W-1:0] wave_al, pcm_al;
    logic signed [PW-1:0]            wave_p, pcm_p;
    logic signed [SW-1:0]            sum;
    logic signed [RW-1:0]            sum_sh;
    logic                            over_hi, over_lo;

    // 11 bit channels sit in the top of the 16 bit range
    assign wave_al = {wave_ch, {AL{1'b0}}};
    assign pcm_al  = {pcm_ch,  {AL{1'b0}}};

    assign wave_p = wave_al * $signed({1'b0, `SND_GAIN_WAVE});
    assign pcm_p  = pcm_al  * $signed({1'b0, `SND_GAIN_PCM});
    assign sum    = wave_p + pcm_p;
    assign sum_sh = sum[SW-1:4];

    assign over_hi = sum_sh > MAXV;
    assign over_lo = sum_sh < MINV;

    always_ff @(posedge clk, negedge srst_n) begin
        if (!srst_n) begin
            mixed <= '0;
            peak  <= 1'b0;
        end else begin
            peak <= over_hi | over_lo;
            if (over_hi) begin
                mixed <= MAXV[`SND_SAMPLE_W-1:0];
            end else if (over_lo) begin
                mixed <= MINV[`SND_SAMPLE_W-1:0];
            end else begin
                mixed <= sum_sh[`SND_SAMPLE_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/snd_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "snd_consts.svh"

module snd_top (
    input  wire                             clk,
    input  wire                             srst_n,
    input  wire                             cen,
    input  wire                             lvbl,
    input  wire  snd_pkg::snd_req_t         cpu_req,
    input  wire  snd_pkg::snd_bus_t         main_bus,
    input  wire  [7:0]                      rom_data,
    input  wire                             rom_ok,
    input  wire  [7:0]                      ram_rdata,
    input  wire  signed [`SND_VOICE_W-1:0]  pcm_snd,
    output logic                            rom_cs,
    output logic [`SND_ROM_AW-1:0]          rom_addr,
    output logic                            bus_busy,
    output logic                            ram_we,
    output logic [`SND_RAM_AW-1:0]          ram_addr,
    output logic [7:0]                      ram_wdata,
    output logic [7:0]                      main_rdata,
    output logic [7:0]                      rd_data,
    output logic                            rd_valid,
    output logic                            irq_n,
    output snd_pkg::snd_sample_t            audio,
    output logic                            peak
);

    snd_pkg::snd_bus_t               wave_bus;
    logic [7:0]                      wave_rdata;
    logic signed [`SND_VOICE_W-1:0]  voice_l, voice_r;
    logic signed [`SND_SAMPLE_W-1:0] mix_l, mix_r;
    logic                            peak_l, peak_r;

    assign audio = {mix_l, mix_r};
    assign peak  = peak_l | peak_r;

    snd_bus_ctrl u_ctrl (
        .clk        ( clk        ),
        .srst_n     ( srst_n     ),
        .lvbl       ( lvbl       ),
        .cpu_req    ( cpu_req    ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .ram_rdata  ( ram_rdata  ),
        .wave_rdata ( wave_rdata ),
        .rom_cs     ( rom_cs     ),
        .rom_addr   ( rom_addr   ),
        .bus_busy   ( bus_busy   ),
        .ram_we     ( ram_we     ),
        .ram_addr   ( ram_addr   ),
        .ram_wdata  ( ram_wdata  ),
        .wave_bus   ( wave_bus   ),
        .rd_data    ( rd_data    ),
        .rd_valid   ( rd_valid   ),
        .irq_n      ( irq_n      )
    );

    wave_voice u_wave (
        .clk        ( clk        ),
        .srst_n     ( srst_n     ),
        .cen        ( cen        ),
        .main_bus   ( main_bus   ),
        .snd_bus    ( wave_bus   ),
        .main_rdata ( main_rdata ),
        .snd_rdata  ( wave_rdata ),
        .voice_l    ( voice_l    ),
        .voice_r    ( voice_r    )
    );

    snd_mixer u_left (
        .clk        ( clk        ),
        .srst_n     ( srst_n     ),
        .wave_ch    ( voice_l    ),
        .pcm_ch     ( pcm_snd    ),     // mono PCM feeds both sides
        .mixed      ( mix_l      ),
        .peak       ( peak_l     )
    );

    snd_mixer u_right (
        .clk        ( clk        ),
        .srst_n     ( srst_n     ),
        .wave_ch    ( voice_r    ),
        .pcm_ch     ( pcm_snd    ),
        .mixed      ( mix_r      ),
        .peak       ( peak_r     )
    );

endmodule

`default_nettype wire

// ==== verification/snd_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module snd_checker (
    input  wire                        clk,
    input  wire                        srst_n,
    input  wire  snd_pkg::snd_req_t    cpu_req,
    input  wire  snd_pkg::snd_bus_t    main_bus,
    input  wire                        lvbl,
    input  wire  signed [10:0]         pcm_snd,
    input  wire                        rom_cs,
    input  wire                        bus_busy,
    input  wire  [16:0]                rom_addr,
    input  wire                        rom_ok,
    input  wire  [7:0]                 rom_data,
    input  wire                        ram_we,
    input  wire  [12:0]                ram_addr,
    input  wire  [7:0]                 ram_wdata,
    input  wire  [7:0]                 main_rdata,
    input  wire  [7:0]                 rd_data,
    input  wire                        rd_valid,
    input  wire                        irq_n,
    input  wire  snd_pkg::snd_sample_t audio,
    input  wire                        peak,
    input  wire                        aud_chk,
    input  wire                        test_end,
    input  wire  [3:0]                 test_id,
    input  wire                        all_done,
    output logic [31:0]                err_cnt
);

    logic [7:0]  wave_sh [0:1023];     // shadow of the shared wave RAM
    logic [7:0]  ram_sh  [0:8191];
    logic [7:0]  rd_q [$];
    int          due_q [$];
    logic [2:0]  bank;
    logic [16:0] rom_exp_addr;
    logic [7:0]  rom_exp, main_exp;
    logic        rom_chk, exp_irq, lvbl_q, exp_busy;
    int          cyc, rom_due, main_due, err_mark, n_pass, n_fail;

    function automatic logic [16:0] rom_addr_ref(input logic [15:0] a, input logic [2:0] bk);
        return (a[15:14] == 2'b11) ? {3'b000, a[13:0]} : {bk, a[13:0]};
    endfunction

    function automatic logic [7:0] read_ref(input logic [15:0] a);
        case (a[15:12])
            4'h5:       return wave_sh[a[9:0]];
            4'h8, 4'h9: return ram_sh[a[12:0]];
            default:    return 8'h00;
        endcase
    endfunction

    function automatic int voice_ref(input logic [3:0] nib, input logic [3:0] vol);
        return (int'(nib) - 8) * int'(vol);
    endfunction

    // unclipped mix with 11 bit inputs sitting 5 bits up and both gains at unity
    function automatic int mix_sum(input int w, input int p);
        return (w + p) * 32;
    endfunction

    function automatic logic [15:0] clip16(input int s);
        if (s > 32767) return 16'h7fff;
        if (s < -32768) return 16'h8000;
        return s[15:0];
    endfunction

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1: return "banking";
            4'd2: return "shared wave RAM";
            4'd3: return "work RAM";
            4'd4: return "interrupt";
            4'd5: return "steady voice";
            default: return "mixer saturation";
        endcase
    endfunction

    task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
        $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        err_cnt++;
    endtask

    task automatic complain(input string what);
        $display("%s at %0t ns", what, $time);
        err_cnt++;
    endtask

    always @(posedge clk) begin : watch
        logic [15:0] a;
        int          sl, sr;
        a = cpu_req.addr;
        if (!srst_n) begin
            cyc      = 0;
            bank     = '0;
            exp_irq  = 1'b1;
            exp_busy = 1'b0;
            lvbl_q   = 1'b0;
            rom_chk  = 1'b0;
            rom_due  = -1;
            main_due = -1;
            err_cnt  = 0;
            err_mark = 0;
            n_pass   = 0;
            n_fail   = 0;
            rd_q.delete();
            due_q.delete();
        end else begin
            cyc++;
            if (irq_n !== exp_irq) mismatch("irq_n", irq_n, exp_irq);
            // busy from the cycle after a ROM read strobe until rom_ok
            if (rom_cs !== exp_busy) mismatch("rom_cs", rom_cs, exp_busy);
            if (bus_busy !== exp_busy) mismatch("bus_busy", bus_busy, exp_busy);
            if (rom_chk) begin
                if (rom_addr !== rom_exp_addr) mismatch("rom_addr", rom_addr, rom_exp_addr);
                rom_chk = 1'b0;
            end
            // read replies where ROM has its own slot
            if (rom_due == cyc) begin
                if (!rd_valid) complain("rd_valid missing after rom_ok");
                else if (rd_data !== rom_exp) mismatch("ROM rd_data", rd_data, rom_exp);
                rom_due = -1;
            end else if (due_q.size() > 0 && due_q[0] == cyc) begin
                if (!rd_valid) complain("rd_valid missing 2 cycles after the strobe");
                else if (rd_data !== rd_q[0]) mismatch("rd_data", rd_data, rd_q[0]);
                void'(rd_q.pop_front());
                void'(due_q.pop_front());
            end else if (rd_valid) begin
                complain("rd_valid without a pending read");
            end
            if (main_due == cyc) begin
                if (main_rdata !== main_exp) mismatch("main_rdata", main_rdata, main_exp);
                main_due = -1;
            end
            if (exp_busy && rom_ok) begin
                rom_exp  = rom_data;
                rom_due  = cyc + 1;
                exp_busy = 1'b0;
            end
            if (ram_we && !(cpu_req.stb && !cpu_req.rnw && a[15:13] == 3'b100))
                complain("ram_we high without a work RAM write");
            if (cpu_req.stb && cpu_req.rnw) begin
                if (a[15:14] == 2'b00 || a[15:14] == 2'b11) begin
                    rom_chk      = 1'b1;
                    exp_busy     = 1'b1;
                    rom_exp_addr = rom_addr_ref(a, bank);
                end else begin
                    rd_q.push_back(read_ref(a));
                    due_q.push_back(cyc + 2);
                end
            end else if (cpu_req.stb) begin
                if (a[15:12] == 4'h5) wave_sh[a[9:0]] = cpu_req.wdata;
                if (a[15:13] == 3'b100) begin
                    if (!ram_we) complain("ram_we low on a work RAM write");
                    else if (ram_addr !== a[12:0]) mismatch("ram_addr", ram_addr, a[12:0]);
                    else if (ram_wdata !== cpu_req.wdata)
                        mismatch("ram_wdata", ram_wdata, cpu_req.wdata);
                    ram_sh[a[12:0]] = cpu_req.wdata;
                end
                if (a[15:14] == 2'b11 && a[13:12] == 2'd0) bank = cpu_req.wdata[6:4];
                if (a[15:14] == 2'b11 && a[13:12] == 2'd2) exp_irq = 1'b1;
            end
            if (main_bus.cs && main_bus.rnw) begin
                main_exp = wave_sh[main_bus.addr];
                main_due = cyc + 1;
            end else if (main_bus.cs) begin
                wave_sh[main_bus.addr] = main_bus.data;
            end
            if (!lvbl && lvbl_q) exp_irq = 1'b0;   // falling edge beats ack
            lvbl_q = lvbl;
            if (aud_chk) begin
                sl = mix_sum(voice_ref(wave_sh[0][7:4], wave_sh[10'h3f2][3:0]), pcm_snd);
                sr = mix_sum(voice_ref(wave_sh[0][7:4], wave_sh[10'h3f3][3:0]), pcm_snd);
                if (audio.left !== clip16(sl)) mismatch("left audio", audio.left, clip16(sl));
                if (audio.right !== clip16(sr)) mismatch("right audio", audio.right, clip16(sr));
                if (peak !== (clip16(sl) != sl[15:0] || clip16(sr) != sr[15:0] ||
                              sl > 32767 || sr > 32767 || sl < -32768 || sr < -32768))
                    complain("peak flag wrong");
            end
            if (test_end) begin
                if (err_cnt == err_mark) begin
                    n_pass++;
                    $display("test %0d %s passed", test_id, test_name(test_id));
                end else begin
                    n_fail++;
                    $display("test %0d %s failed with %0d errors", test_id,
                             test_name(test_id), err_cnt - err_mark);
                end
                err_mark = err_cnt;
            end
            if (all_done) begin
                if (due_q.size() > 0 || rom_due >= 0 || exp_busy)
                    complain("reads left without a reply");
                $display("%0d tests passed, %0d failed, %0d errors", n_pass, n_fail, err_cnt);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/snd_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module snd_tb;

    localparam int N_BANK      = 8;
    localparam int N_WAVE      = 8;
    localparam int N_RAM       = 8;
    // cycle budget per test allowing ROM reads up to 6 wait cycles
    localparam int TEST_CYCLES = N_BANK * 30 + N_WAVE * 16 + N_RAM * 10 + 60 + 2 * 130 + 4 * 110;

    logic clk, srst_n, cen, lvbl, rom_ok;
    snd_pkg::snd_req_t    cpu_req;
    snd_pkg::snd_bus_t    main_bus;
    logic [7:0]           rom_data, ram_rdata, main_rdata, rd_data, ram_wdata;
    logic signed [10:0]   pcm_snd;
    logic                 rom_cs, bus_busy, ram_we, rd_valid, irq_n, peak;
    logic [16:0]          rom_addr;
    logic [12:0]          ram_addr;
    snd_pkg::snd_sample_t audio;
    logic                 aud_chk, test_end, all_done;
    logic [3:0]           test_id;
    logic [31:0]          err_cnt, r, r2;
    logic [1:0]           cen_div;
    logic [7:0]           wram [0:8191];
    logic [15:0]          addr_list [0:7];
    integer               seed = 32'h41cb_402d;
    integer               rom_seed = 32'h41cb_402d;  // ROM latency draws
    int                   rom_wait = -1;

    snd_top i_dut (.*);

    snd_checker i_chk (.*);

    function automatic logic [7:0] rom_byte(input logic [16:0] a);
        return a[7:0] ^ a[16:9] ^ 8'h5a;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 4 * 2);
        $display("watchdog expired, run did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    always @(posedge clk) begin
        rom_ok <= 1'b0;
        if (rom_cs && !rom_ok) begin
            if (rom_wait < 0) rom_wait = 1 + ({$random(rom_seed)} % 6);
            rom_wait--;
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_byte(rom_addr);
                rom_wait = -1;
            end
        end
    end

    always @(posedge clk) begin
        if (ram_we) wram[ram_addr] <= ram_wdata;
        ram_rdata <= wram[ram_addr];
        cen_div   <= cen_div + 2'd1;
        cen       <= &cen_div;     // one pulse every 4 clocks
    end

    task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        cpu_req <= {a, 1'b0, d, 1'b1};
        @(posedge clk);
        cpu_req.stb <= 1'b0;
    endtask

    task automatic cpu_read(input logic [15:0] a);
        int n;
        @(posedge clk);
        cpu_req <= {a, 1'b1, 8'h00, 1'b1};
        @(posedge clk);
        cpu_req.stb <= 1'b0;
        n = 0;
        while (!rd_valid) begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                $display("no rd_valid for the read of %h", a);
                $display("=== FAIL ===");
                $finish;
            end
        end
    endtask

    task automatic main_access(input logic rnw, input logic [9:0] a, input logic [7:0] d);
        @(posedge clk);
        main_bus <= {1'b1, rnw, a, d};
        @(posedge clk);
        main_bus.cs <= 1'b0;
        @(posedge clk);
    endtask

    task automatic pulse_end(input logic [3:0] id);
        @(posedge clk);
        test_id  <= id;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    task automatic fill_wave(input logic [3:0] nib);
        for (int i = 0; i < 32; i++) main_access(1'b0, 10'(i), {nib, nib});
    endtask

    task automatic set_voice(input logic [3:0] vl, input logic [3:0] vr);
        cpu_write(16'h53f0, 8'h34);
        cpu_write(16'h53f1, 8'h12);
        cpu_write(16'h53f2, {4'h0, vl});
        cpu_write(16'h53f3, {4'h0, vr});
    endtask

    task automatic audio_at(input logic signed [10:0] pcm);
        @(posedge clk);
        pcm_snd <= pcm;
        repeat (16) @(posedge clk);
        aud_chk <= 1'b1;
        @(posedge clk);
        aud_chk <= 1'b0;
    endtask

    initial begin
        srst_n    = 1'b0;
        cen       = 1'b0;
        cen_div   = 2'd0;
        lvbl      = 1'b1;
        rom_ok    = 1'b0;
        rom_data  = 8'h00;
        ram_rdata = 8'h00;
        pcm_snd   = '0;
        cpu_req   = '0;
        main_bus  = '0;
        aud_chk   = 1'b0;
        test_end  = 1'b0;
        all_done  = 1'b0;
        test_id   = 4'd0;
        repeat (8) @(posedge clk);
        srst_n <= 1'b1;
        for (int i = 0; i < N_BANK; i++) begin
            r = $random(seed);
            r2 = $random(seed);
            cpu_write(16'hc000, {1'b0, r[2:0], 4'h0});
            cpu_read({2'b00, r[29:16]});
            cpu_read({2'b11, r2[13:0]});   // fixed bank 0 window
        end
        pulse_end(4'd1);
        for (int i = 0; i < N_WAVE; i++) begin
            r = $random(seed);
            main_access(1'b0, r[9:0], r[23:16]);
            cpu_read({6'b010100, r[9:0]});
            cpu_write({6'b010100, r[9:0]}, r[31:24]);
            main_access(1'b1, r[9:0], 8'h00);
        end
        pulse_end(4'd2);
        for (int i = 0; i < N_RAM; i++) begin
            r = $random(seed);
            addr_list[i] = {3'b100, r[12:0]};
            cpu_write(addr_list[i], r[23:16]);
        end
        for (int i = 0; i < N_RAM; i++) cpu_read(addr_list[i]);
        pulse_end(4'd3);
        repeat (2) begin
            @(posedge clk);
            lvbl <= 1'b0;
            repeat (6) @(posedge clk);
            cpu_write(16'he000, 8'h00);
            repeat (4) @(posedge clk);
            lvbl <= 1'b1;
            repeat (4) @(posedge clk);
        end
        pulse_end(4'd4);
        repeat (2) begin
            r = $random(seed);
            fill_wave(r[3:0]);
            set_voice(r[7:4], r[11:8]);
            audio_at(11'sd0);
        end
        pulse_end(4'd5);
        set_voice(4'hf, 4'hf);
        fill_wave(4'hf);
        audio_at(11'sd1000);
        audio_at(11'sd900);
        fill_wave(4'h0);
        audio_at(-11'sd1000);
        audio_at(-11'sd900);
        pulse_end(4'd6);
        @(posedge clk);
        all_done <= 1'b1;
        @(posedge clk);
        all_done <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/snd_pkg.sv
logic/snd_bus_ctrl.sv
logic/wave_voice.sv
logic/snd_mixer.sv
logic/snd_top.sv
verification/snd_checker.sv
verification/snd_tb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module snd_tb -f files.f

sim:
	verilator --binary --timing -Wno-fatal --top-module snd_tb -f files.f -o snd_sim
	./obj_dir/snd_sim | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
